/* src.f */
hdl/core_pkg.sv
hdl/bus_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/execute_stage.sv
hdl/memory_controller.sv
hdl/rv32_core.sv
bench/bus_memory.sv
bench/rv32_core_tb.sv

/* Makefile */
TOP = rv32_core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/rv32_core_tb.sv */
`default_nettype none

module rv32_core_tb import core_pkg::*, bus_pkg::*; ();

  localparam int       PERIOD   = 10;
  localparam int       NPROG    = 4;
  localparam word_t    RESET_PC = 32'h0;
  localparam word_t    ECALL_W  = 32'h0000_0073;
  localparam bus_req_t NO_STORE = '0;

  logic     CLK;
  logic     nRST;
  logic     halt;
  logic     clear;
  logic     load_en;
  word_t    load_addr;
  word_t    load_data;
  bus_req_t core_req;
  bus_rsp_t core_rsp;

  int store_errs = 0;
  int word_errs  = 0;
  int bus_errs   = 0;

  // encoders for each instruction format
  function automatic word_t r_op(int f7, int f3, int rd, int rs1, int rs2);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP};
  endfunction

  function automatic word_t i_op(opcode_t op, int f3, int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
  endfunction

  function automatic word_t lui_op(int rd, int imm);
    return {20'(imm), 5'(rd), LUI};
  endfunction

  function automatic word_t sw_op(int rs2, int rs1, int imm);
    logic [11:0] v;
    v = 12'(imm);
    return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], STORE};
  endfunction

  // offset relative to the branch itself
  function automatic word_t br_op(int f3, int rs1, int rs2, int off);
    logic [12:0] v;
    v = 13'(off);
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], BRANCH};
  endfunction

  function automatic bus_req_t store_req(word_t addr, word_t data);
    bus_req_t r;
    r       = '0;
    r.addr  = addr;
    r.wdata = data;
    r.wen   = 1'b1;
    return r;
  endfunction

  // program rows, padded with ecall
  logic [0:15][31:0] prog [NPROG] = '{
    // alu ops, lui, write to x0
    {i_op(OP_IMM, 0, 1, 0, 100), i_op(OP_IMM, 0, 2, 0, -7), r_op(0, 0, 3, 1, 2),
     r_op(32, 0, 4, 1, 2), lui_op(5, 'h12345), r_op(0, 4, 6, 5, 1), r_op(0, 6, 7, 5, 2),
     r_op(0, 7, 8, 2, 1), i_op(OP_IMM, 0, 0, 1, 5), sw_op(3, 0, 'h200), sw_op(4, 0, 'h204),
     sw_op(6, 0, 'h208), sw_op(7, 0, 'h20c), sw_op(8, 0, 'h210), sw_op(0, 0, 'h214), ECALL_W},
    // loads used right away
    {i_op(OP_IMM, 0, 1, 0, 'h123), lui_op(2, 'habcde), r_op(0, 6, 2, 2, 1),
     sw_op(2, 0, 'h300), i_op(LOAD, 2, 3, 0, 'h300), r_op(0, 0, 4, 3, 1), sw_op(4, 0, 'h304),
     i_op(LOAD, 2, 5, 0, 'h304), r_op(32, 0, 6, 5, 3), sw_op(6, 0, 'h308), {6{ECALL_W}}},
    // beq/bne taken and not taken
    {i_op(OP_IMM, 0, 1, 0, 5), i_op(OP_IMM, 0, 2, 0, 5), i_op(OP_IMM, 0, 3, 0, 9),
     br_op(0, 1, 2, 8), sw_op(3, 0, 'h400), sw_op(1, 0, 'h404), br_op(1, 1, 2, 8),
     sw_op(2, 0, 'h408), br_op(0, 1, 3, 8), sw_op(3, 0, 'h40c), br_op(1, 1, 3, 12),
     sw_op(1, 0, 'h410), sw_op(2, 0, 'h414), sw_op(3, 0, 'h418), {2{ECALL_W}}},
    // stores behind the ecall
    {i_op(OP_IMM, 0, 1, 0, 'h55), sw_op(1, 0, 'h500), ECALL_W, sw_op(1, 0, 'h504),
     sw_op(1, 0, 'h508), {11{ECALL_W}}}
  };

  // expected store sequence per row
  bus_req_t [0:7] exp_st [NPROG] = '{
    {store_req('h200, 'h5d), store_req('h204, 'h6b), store_req('h208, 'h1234_5064),
     store_req('h20c, 'hffff_fff9), store_req('h210, 'h60), store_req('h214, 0),
     {2{NO_STORE}}},
    {store_req('h300, 'habcd_e123), store_req('h304, 'habcd_e246), store_req('h308, 'h123),
     {5{NO_STORE}}},
    {store_req('h404, 5), store_req('h408, 5), store_req('h40c, 9), store_req('h418, 9),
     {4{NO_STORE}}},
    {store_req('h500, 'h55), {7{NO_STORE}}}
  };
  int exp_n [NPROG] = '{6, 3, 4, 1};

  rv32_core #(.RESET_PC(RESET_PC)) uut (
    .CLK, .nRST, .halt, .bus_req(core_req), .bus_rsp(core_rsp)
  );

  bus_memory mem (
    .CLK, .nRST, .clear, .load_en, .load_addr, .load_data,
    .bus_req(core_req), .bus_rsp(core_rsp)
  );

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  task automatic check_store(bus_req_t got, bus_req_t want, string what);
    if (got !== want) begin
      store_errs++;
      $display("Error at %0t: %s: got addr %h data %h ren %b wen %b, expected addr %h data %h",
               $time, what, got.addr, got.wdata, got.ren, got.wen, want.addr, want.wdata);
    end
  endtask

  task automatic check_word(word_t got, word_t want, string what);
    if (got !== want) begin
      word_errs++;
      $display("Error at %0t: %s: got %h, expected %h", $time, what, got, want);
    end
  endtask

  // load the row while the core sits halted or in reset
  // then reset for 8 cycles and wait for halt
  task automatic run_program(logic [1:0] row);
    clear = 1'b1;
    @(negedge CLK);
    clear = 1'b0;
    for (int i = 0; i < 16; i++) begin
      load_en   = 1'b1;
      load_addr = RESET_PC + word_t'(4 * i);
      load_data = prog[row][i[3:0]];
      @(negedge CLK);
    end
    load_en = 1'b0;
    nRST    = 1'b0;
    repeat (8) @(negedge CLK);
    nRST = 1'b1;
    while (!halt) @(negedge CLK);
  endtask

  // bus must stay quiet and halt high
  task automatic watch_after_halt(logic [1:0] row);
    mc_state_t st;
    repeat (20) begin
      if (core_req.ren || core_req.wen) begin
        st = uut.mc.state;
        bus_errs++;
        $display("Error at %0t: program %0d: bus request at %h after halt, controller %s",
                 $time, row, core_req.addr, st.name());
      end
      if (!halt) begin
        bus_errs++;
        $display("Error at %0t: program %0d: halt dropped before reset", $time, row);
      end
      @(negedge CLK);
    end
  endtask

  task automatic compare_results(logic [1:0] row);
    for (int k = 0; k < exp_n[row]; k++) begin
      if (k < mem.log_n)
        check_store(mem.log_q[k[4:0]], exp_st[row][k[2:0]],
                    $sformatf("program %0d store %0d", row, k));
      check_word(mem.ram[exp_st[row][k[2:0]].addr[11:2]], exp_st[row][k[2:0]].wdata,
                 $sformatf("program %0d memory at %h", row, exp_st[row][k[2:0]].addr));
    end
    // catches missing, repeated and wrong-path stores
    check_word(word_t'(mem.log_n), word_t'(exp_n[row]),
               $sformatf("program %0d store count", row));
  endtask

  initial begin
    nRST      = 1'b0;
    clear     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    @(negedge CLK);
    for (int r = 0; r < NPROG; r++) begin
      run_program(2'(r));
      watch_after_halt(2'(r));
      compare_results(2'(r));
    end
    $display("errors: store %0d, word %0d, bus %0d", store_errs, word_errs, bus_errs);
    if (store_errs + word_errs + bus_errs == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // 16 instructions of up to 8 cycles for every row
  // plus 45 cycles of loading, reset and quiet check
  initial begin
    #(NPROG * (16 * 8 + 45) * PERIOD);
    $display("Timeout: the run did not reach halt in the time allowed");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/bus_memory.sv */
`default_nettype none

module bus_memory import bus_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        clear,
  input  logic        load_en,
  input  logic [31:0] load_addr,
  input  logic [31:0] load_data,
  input  bus_req_t    bus_req,
  output bus_rsp_t    bus_rsp
);

  // 4 KB, word addressed
  logic [31:0] ram [1024];
  // completed writes in order
  bus_req_t    log_q [32];
  int          log_n;

  logic [15:0] lfsr;
  logic [15:0] lfsr_a;
  logic [15:0] lfsr_b;
  // busy cycles left for the current transfer
  logic [1:0]  wait_left;
  logic        active;

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // two steps, one per bit of the wait count
  assign lfsr_a = lfsr_step(lfsr);
  assign lfsr_b = lfsr_step(lfsr_a);
  assign active = bus_req.ren || bus_req.wen;

  always_comb begin
    bus_rsp.busy  = active && (wait_left != 2'd0);
    bus_rsp.rdata = bus_req.ren ? ram[bus_req.addr[11:2]] : 32'h0;
  end

  // next wait count drawn when a transfer completes
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lfsr      <= 16'd26;
      wait_left <= 2'd0;
    end else if (active) begin
      if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else begin
        wait_left <= {lfsr_b[0], lfsr_a[0]};
        lfsr      <= lfsr_b;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (clear) begin
      // fill tracks the byte address
      for (int i = 0; i < 1024; i++)
        ram[i[9:0]] <= 32'hC0DE_0000 | {20'h0, i[9:0], 2'b00};
      log_n <= 0;
    end else if (load_en) begin
      ram[load_addr[11:2]] <= load_data;
    end else if (bus_req.wen && !bus_rsp.busy) begin
      ram[bus_req.addr[11:2]] <= bus_req.wdata;
      if (log_n < 32)
        log_q[log_n[4:0]] <= bus_req;
      log_n <= log_n + 1;
    end
  end

endmodule

`default_nettype wire

/* hdl/rv32_core.sv */
`default_nettype none

module rv32_core import core_pkg::*, bus_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic     CLK,
  input  logic     nRST,
  output logic     halt,
  output bus_req_t bus_req,
  input  bus_rsp_t bus_rsp
);

  fetch_exec_t fetch_exec;
  logic        stall;
  logic        redirect;
  word_t       redirect_pc;
  logic        halt_instr;

  // per-requester buses into the controller
  bus_req_t    ibus_req;
  bus_rsp_t    ibus_rsp;
  bus_req_t    dbus_req;
  bus_rsp_t    dbus_rsp;

  // register file ports
  reg_idx_t    rs1_idx;
  reg_idx_t    rs2_idx;
  word_t       rs1_data;
  word_t       rs2_data;
  logic        rf_we;
  reg_idx_t    rf_waddr;
  word_t       rf_wdata;

  fetch_stage #(.RESET_PC(RESET_PC)) fetch (
    .CLK, .nRST, .halt, .stall, .redirect, .redirect_pc,
    .ibus_req, .ibus_rsp, .fetch_exec
  );

  execute_stage execute (
    .CLK, .nRST, .fetch_exec, .stall, .redirect, .redirect_pc,
    .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
    .rf_we, .rf_waddr, .rf_wdata,
    .dbus_req, .dbus_rsp, .halt_instr
  );

  reg_file rf (
    .CLK, .nRST, .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
    .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
  );

  memory_controller mc (
    .CLK, .nRST, .ibus_req, .ibus_rsp, .dbus_req, .dbus_rsp,
    .bus_req, .bus_rsp
  );

  // halt latch
  // set by a retiring ecall, only reset clears it
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      halt <= 1'b0;
    else if (halt_instr)
      halt <= 1'b1;
  end

endmodule

`default_nettype wire

/* hdl/memory_controller.sv */
`default_nettype none

module memory_controller import bus_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  bus_req_t ibus_req,
  output bus_rsp_t ibus_rsp,
  input  bus_req_t dbus_req,
  output bus_rsp_t dbus_rsp,
  output bus_req_t bus_req,
  input  bus_rsp_t bus_rsp
);

  // registered owner, held across busy cycles
  mc_state_t state;
  // owner in the current cycle
  mc_state_t sel;

  logic i_act;
  logic d_act;

  assign i_act = ibus_req.ren || ibus_req.wen;
  assign d_act = dbus_req.ren || dbus_req.wen;

  // arbitration from idle, data first
  always_comb begin
    sel = state;
    if (state == MC_IDLE) begin
      if (d_act)
        sel = MC_DATA;
      else if (i_act)
        sel = MC_INSTR;
    end
  end

  // forward the owner's request
  always_comb begin
    case (sel)
      MC_DATA:  bus_req = dbus_req;
      MC_INSTR: bus_req = ibus_req;
      default:  bus_req = '0;
    endcase
  end

  // read data goes to both, only the owner sees busy low
  always_comb begin
    ibus_rsp.rdata = bus_rsp.rdata;
    dbus_rsp.rdata = bus_rsp.rdata;
    ibus_rsp.busy  = (sel == MC_INSTR) ? bus_rsp.busy : 1'b1;
    dbus_rsp.busy  = (sel == MC_DATA) ? bus_rsp.busy : 1'b1;
  end

  // keep ownership until the completing cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      state <= MC_IDLE;
    else if ((sel != MC_IDLE) && bus_rsp.busy)
      state <= sel;
    else
      state <= MC_IDLE;
  end

  // the owner keeps its request up and unchanged through busy
  a_req_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (sel != MC_IDLE) && bus_rsp.busy |=> $stable(bus_req));

  // an instruction read that lost to data stays pending
  a_wait_pending: assert property (@(posedge CLK) disable iff (!nRST)
    (sel == MC_DATA) && i_act |=> i_act);

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`default_nettype none

module execute_stage import core_pkg::*, bus_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  fetch_exec_t fetch_exec,
  output logic        stall,
  output logic        redirect,
  output word_t       redirect_pc,
  output reg_idx_t    rs1_idx,
  output reg_idx_t    rs2_idx,
  input  word_t       rs1_data,
  input  word_t       rs2_data,
  output logic        rf_we,
  output reg_idx_t    rf_waddr,
  output word_t       rf_wdata,
  output bus_req_t    dbus_req,
  input  bus_rsp_t    dbus_rsp,
  output logic        halt_instr
);

  word_t    instr;
  opcode_t  op;
  alu_op_t  alu_op;
  logic     valid;

  word_t    imm_i;
  word_t    imm_s;
  word_t    imm_b;
  word_t    imm_u;

  word_t    alu_b;
  word_t    alu_res;
  logic     is_load;
  logic     is_store;
  logic     alu_wb;
  logic     equal;

  assign valid = fetch_exec.valid;
  assign instr = fetch_exec.instr;
  assign op    = opcode_t'(instr[6:0]);

  assign rs1_idx  = instr[19:15];
  assign rs2_idx  = instr[24:20];
  assign rf_waddr = instr[11:7];

  // sign extended immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  // alu function select
  always_comb begin
    alu_op = ALU_ADD;
    case (op)
      OP: begin
        case (instr[14:12])
          3'b000:  alu_op = instr[30] ? ALU_SUB : ALU_ADD;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: alu_op = ALU_ADD;
        endcase
      end
      LUI:     alu_op = ALU_PASS;
      default: alu_op = ALU_ADD;
    endcase
  end

  // register operand for OP, immediate otherwise
  always_comb begin
    case (op)
      OP:      alu_b = rs2_data;
      LUI:     alu_b = imm_u;
      default: alu_b = imm_i;
    endcase
  end

  always_comb begin
    case (alu_op)
      ALU_SUB:  alu_res = rs1_data - alu_b;
      ALU_AND:  alu_res = rs1_data & alu_b;
      ALU_OR:   alu_res = rs1_data | alu_b;
      ALU_XOR:  alu_res = rs1_data ^ alu_b;
      ALU_PASS: alu_res = alu_b;
      default:  alu_res = rs1_data + alu_b;
    endcase
  end

  // branch resolution
  // funct3[0] picks bne over beq
  assign equal       = rs1_data == rs2_data;
  assign redirect    = valid && (op == BRANCH) && (instr[12] ? !equal : equal);
  assign redirect_pc = fetch_exec.pc + imm_b;

  // data bus, word aligned only
  assign is_load  = valid && (op == LOAD);
  assign is_store = valid && (op == STORE);

  always_comb begin
    dbus_req       = '0;
    dbus_req.addr  = rs1_data + (is_store ? imm_s : imm_i);
    dbus_req.wdata = rs2_data;
    dbus_req.ren   = is_load;
    dbus_req.wen   = is_store;
  end

  // hold fetch until the transfer completes
  assign stall = (is_load || is_store) && dbus_rsp.busy;

  // writeback, x0 filtered in the register file
  assign alu_wb   = valid && ((op == OP) || (op == OP_IMM) || (op == LUI));
  assign rf_we    = alu_wb || (is_load && !dbus_rsp.busy);
  assign rf_wdata = is_load ? dbus_rsp.rdata : alu_res;

  // ecall retires as halt
  assign halt_instr = valid && (op == SYSTEM);

  // a load or store under stall stays put in the pipeline register
  a_hold_on_stall: assert property (@(posedge CLK) disable iff (!nRST)
    stall |=> $stable(fetch_exec));

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`default_nettype none

module fetch_stage import core_pkg::*, bus_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        halt,
  input  logic        stall,
  input  logic        redirect,
  input  word_t       redirect_pc,
  output bus_req_t    ibus_req,
  input  bus_rsp_t    ibus_rsp,
  output fetch_exec_t fetch_exec
);

  // address of the open or next read
  word_t pc;
  // read issued but not yet completed
  logic  open;
  // open read belongs to the wrong path
  logic  discard;
  word_t tgt_q;

  logic  fe_valid;
  word_t fe_instr;
  word_t fe_pc;

  logic  ecall_held;
  logic  start;
  logic  complete;

  // no fetch beyond an ecall sitting in execute
  assign ecall_held = fe_valid && (opcode_t'(fe_instr[6:0]) == SYSTEM);

  // new read only when execute will accept the result
  assign start    = !halt && !stall && !redirect && !ecall_held;
  assign complete = ibus_req.ren && !ibus_rsp.busy;

  always_comb begin
    ibus_req       = '0;
    ibus_req.addr  = pc;
    ibus_req.ren   = open || start;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc       <= RESET_PC;
      open     <= 1'b0;
      discard  <= 1'b0;
      fe_valid <= 1'b0;
    end else begin
      open <= ibus_req.ren && ibus_rsp.busy;
      if (complete) begin
        discard  <= 1'b0;
        // wrong-path word is dropped here
        fe_valid <= !discard && !redirect;
        if (discard)
          pc <= tgt_q;
        else if (redirect)
          pc <= redirect_pc;
        else
          pc <= pc + 32'd4;
      end else begin
        if (!stall)
          fe_valid <= 1'b0;
        if (redirect) begin
          // read still open, keep its address until done
          if (ibus_req.ren)
            discard <= 1'b1;
          else
            pc <= redirect_pc;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (redirect)
      tgt_q <= redirect_pc;
    if (complete) begin
      fe_instr <= ibus_rsp.rdata;
      fe_pc    <= pc;
    end
  end

  assign fetch_exec = '{valid: fe_valid, instr: fe_instr, pc: fe_pc};

  // a new word never lands on an instruction execute still holds
  a_no_overwrite: assert property (@(posedge CLK) disable iff (!nRST)
    complete |-> !(fe_valid && stall));

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`default_nettype none

module reg_file import core_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t waddr,
  input  word_t    wdata
);

  word_t regs [32];

  // write on the edge
  // x0 never written, stays at its reset value
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous reads
  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

endmodule

`default_nettype wire

/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  // generic bus request
  // held stable by the requester while busy is high
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        ren;
    logic        wen;
  } bus_req_t;

  // generic bus response
  // rdata valid in the cycle busy is low
  typedef struct packed {
    logic [31:0] rdata;
    logic        busy;
  } bus_rsp_t;

  // memory controller ownership
  typedef enum logic [1:0] {
    MC_IDLE,
    MC_INSTR,
    MC_DATA
  } mc_state_t;

endpackage

`default_nettype wire

/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

  // basic data and address word
  typedef logic [31:0] word_t;

  // architectural register index
  typedef logic [4:0] reg_idx_t;

  // major opcodes, instr[6:0]
  // only the subset the core runs
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011
  } opcode_t;

  // alu functions
  // pass forwards operand b, used by lui
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS
  } alu_op_t;

  // fetch to execute pipeline register
  typedef struct packed {
    // instruction present
    logic  valid;
    // raw instruction word
    word_t instr;
    // address it was fetched from
    word_t pc;
  } fetch_exec_t;

endpackage

`default_nettype wire
